/* flist.f */
design/axi_bridge_pkg.sv
design/axi_rw_if.sv
design/axi_port_arbiter.sv
design/axi_master_ctrl.sv
design/axi_wdata_lane.sv
design/axi_rdata_align.sv
design/axi_bridge_top.sv
tb/axi_slave_mem.sv
tb/tb_axi_bridge.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_axi_bridge -f flist.f -o sim_axi_bridge
./obj_dir/sim_axi_bridge > sim.log 2>&1 || true
cat sim.log

if grep -q "^TEST OK$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* tb/tb_axi_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_axi_bridge;

    localparam int TIMEOUT_CYCLES = 200;
    // which requester a row drives
    localparam logic [1:0] PORT_LSU  = 2'd0;
    localparam logic [1:0] PORT_IF   = 2'd1;
    localparam logic [1:0] PORT_BOTH = 2'd2;
    localparam axi_bridge_pkg::size_e SZ_B = axi_bridge_pkg::SIZE_B;
    localparam axi_bridge_pkg::size_e SZ_H = axi_bridge_pkg::SIZE_H;
    localparam axi_bridge_pkg::size_e SZ_W = axi_bridge_pkg::SIZE_W;
    localparam axi_bridge_pkg::size_e SZ_D = axi_bridge_pkg::SIZE_D;

    logic                  clock;
    logic                  reset_n;
    // requester side named after the DUT ports
    logic                  if_valid_i;
    logic [31:0]           if_addr_i;
    logic                  if_ready_o;
    logic [31:0]           if_rdata_o;
    logic                  lsu_valid_i;
    logic                  lsu_write_i;
    axi_bridge_pkg::size_e lsu_size_i;
    logic [31:0]           lsu_addr_i;
    logic [63:0]           lsu_wdata_i;
    logic                  lsu_ready_o;
    logic [63:0]           lsu_rdata_o;
    logic                  lsu_err_o;
    // bus between bridge and memory model
    logic                  axi_aw_ready_i;
    logic                  axi_aw_valid_o;
    logic [31:0]           axi_aw_addr_o;
    logic                  axi_w_ready_i;
    logic                  axi_w_valid_o;
    logic [63:0]           axi_w_data_o;
    logic [7:0]            axi_w_strb_o;
    logic                  axi_w_last_o;
    logic                  axi_b_ready_o;
    logic                  axi_b_valid_i;
    logic [1:0]            axi_b_resp_i;
    logic                  axi_ar_ready_i;
    logic                  axi_ar_valid_o;
    logic [31:0]           axi_ar_addr_o;
    logic                  axi_r_ready_o;
    logic                  axi_r_valid_i;
    logic [1:0]            axi_r_resp_i;
    logic [63:0]           axi_r_data_i;

    // table columns; data is write data or expected read data
    string                 t_name [$];
    logic [1:0]            t_port [$];
    logic                  t_write [$];
    axi_bridge_pkg::size_e t_size [$];
    logic [31:0]           t_addr [$];
    logic [63:0]           t_data [$];
    logic                  t_err [$];

    axi_bridge_top u_dut (.*);

    axi_slave_mem u_mem (
        .clock      (clock),
        .reset_n    (reset_n),
        .aw_valid_i (axi_aw_valid_o),
        .aw_ready_o (axi_aw_ready_i),
        .aw_addr_i  (axi_aw_addr_o),
        .w_valid_i  (axi_w_valid_o),
        .w_ready_o  (axi_w_ready_i),
        .w_data_i   (axi_w_data_o),
        .w_strb_i   (axi_w_strb_o),
        .b_valid_o  (axi_b_valid_i),
        .b_ready_i  (axi_b_ready_o),
        .b_resp_o   (axi_b_resp_i),
        .ar_valid_i (axi_ar_valid_o),
        .ar_ready_o (axi_ar_ready_i),
        .ar_addr_i  (axi_ar_addr_o),
        .r_valid_o  (axi_r_valid_i),
        .r_ready_i  (axi_r_ready_o),
        .r_data_o   (axi_r_data_i),
        .r_resp_o   (axi_r_resp_i)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    task automatic add_row(input string name, input logic [1:0] port, input logic write,
                           input axi_bridge_pkg::size_e size, input logic [31:0] addr,
                           input logic [63:0] data, input logic err);
        t_name.push_back(name);
        t_port.push_back(port);
        t_write.push_back(write);
        t_size.push_back(size);
        t_addr.push_back(addr);
        t_data.push_back(data);
        t_err.push_back(err);
    endtask

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    // one table row on one or both ports
    task automatic run_step(input int idx);
        logic        lsu_done;
        logic        if_done;
        int          cycles;
        logic [31:0] if_exp;
        lsu_done = (t_port[idx] == PORT_IF);
        if_done  = (t_port[idx] == PORT_LSU);
        cycles   = 0;
        // fetch half of a shared row reads the upper word
        if_exp   = (t_port[idx] == PORT_BOTH) ? t_data[idx][63:32] : t_data[idx][31:0];
        @(posedge clock);
        if (!lsu_done) begin
            lsu_valid_i <= 1'b1;
            lsu_write_i <= t_write[idx];
            lsu_size_i  <= t_size[idx];
            lsu_addr_i  <= t_addr[idx];
            lsu_wdata_i <= t_data[idx];
        end
        if (!if_done) begin
            if_valid_i <= 1'b1;
            if_addr_i  <= (t_port[idx] == PORT_BOTH) ? t_addr[idx] + 32'd4 : t_addr[idx];
        end
        while (!(lsu_done && if_done)) begin
            // sample away from the driving edge
            @(negedge clock);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                stop_run($sformatf("%s: %s port never answered", t_name[idx],
                                   lsu_done ? "fetch" : "load/store"));
            end
            // a single-beat write marks its only beat as the last
            if (axi_w_valid_o) begin
                assert (axi_w_last_o) else
                    stop_run($sformatf("CHECK FAILED %s w_last: expected 1, actual %0d",
                                       t_name[idx], axi_w_last_o));
            end
            if (!lsu_done && lsu_ready_o) begin
                lsu_done = 1'b1;
                assert (lsu_err_o == t_err[idx]) else
                    stop_run($sformatf("CHECK FAILED %s lsu_err: expected %0d, actual %0d",
                                       t_name[idx], t_err[idx], lsu_err_o));
                // rdata only means something on a clean read
                if (!t_write[idx] && !t_err[idx]) begin
                    assert (lsu_rdata_o == t_data[idx]) else
                        stop_run($sformatf("CHECK FAILED %s lsu_rdata: expected %h, actual %h",
                                           t_name[idx], t_data[idx], lsu_rdata_o));
                end
            end
            if (!if_done && if_ready_o) begin
                if_done = 1'b1;
                // load/store has priority on a shared start
                assert (lsu_done) else
                    stop_run($sformatf("%s: fetch finished before load/store", t_name[idx]));
                assert (if_rdata_o == if_exp) else
                    stop_run($sformatf("CHECK FAILED %s if_rdata: expected %h, actual %h",
                                       t_name[idx], if_exp, if_rdata_o));
            end
            // drop valid after its ready cycle
            @(posedge clock);
            if (lsu_done) lsu_valid_i <= 1'b0;
            if (if_done) if_valid_i <= 1'b0;
        end
    endtask

    initial begin
        reset_n     <= 1'b0;
        if_valid_i  <= 1'b0;
        if_addr_i   <= '0;
        lsu_valid_i <= 1'b0;
        lsu_write_i <= 1'b0;
        lsu_size_i  <= SZ_B;
        lsu_addr_i  <= '0;
        lsu_wdata_i <= '0;
        // memory starts at zero so each expected value follows from the rows above it
        add_row("dword_write", PORT_LSU, 1'b1, SZ_D, 32'h040, 64'h0123_4567_89ab_cdef, 1'b0);
        add_row("dword_read", PORT_LSU, 1'b0, SZ_D, 32'h040, 64'h0123_4567_89ab_cdef, 1'b0);
        // upper garbage must stay off the bus lanes
        add_row("word_write", PORT_LSU, 1'b1, SZ_W, 32'h044, 64'h7777_7777_cafe_f00d, 1'b0);
        add_row("half_write", PORT_LSU, 1'b1, SZ_H, 32'h046, 64'h1111_2222_3333_beef, 1'b0);
        add_row("byte_write", PORT_LSU, 1'b1, SZ_B, 32'h041, 64'hffff_ffff_ffff_ff5a, 1'b0);
        add_row("merged_read", PORT_LSU, 1'b0, SZ_D, 32'h040, 64'hbeef_f00d_89ab_5aef, 1'b0);
        // zero-extended narrow reads
        add_row("byte_read", PORT_LSU, 1'b0, SZ_B, 32'h045, 64'h0000_0000_0000_00f0, 1'b0);
        add_row("byte_read_top", PORT_LSU, 1'b0, SZ_B, 32'h047, 64'h0000_0000_0000_00be, 1'b0);
        add_row("half_read", PORT_LSU, 1'b0, SZ_H, 32'h042, 64'h0000_0000_0000_89ab, 1'b0);
        add_row("word_read", PORT_LSU, 1'b0, SZ_W, 32'h044, 64'h0000_0000_beef_f00d, 1'b0);
        add_row("fetch_read", PORT_IF, 1'b0, SZ_W, 32'h040, 64'h0000_0000_89ab_5aef, 1'b0);
        add_row("both_ports", PORT_BOTH, 1'b0, SZ_D, 32'h040, 64'hbeef_f00d_89ab_5aef, 1'b0);
        add_row("err_write", PORT_LSU, 1'b1, SZ_D, 32'h900, 64'hdead_beef_dead_beef, 1'b1);
        add_row("err_read", PORT_LSU, 1'b0, SZ_D, 32'h900, 64'h0, 1'b1);
        // 0x900 would alias here if the bad write had landed
        add_row("after_err_read", PORT_LSU, 1'b0, SZ_D, 32'h100, 64'h0, 1'b0);
        repeat (4) @(posedge clock);
        reset_n <= 1'b1;
        @(negedge clock);
        assert (!lsu_ready_o && !if_ready_o && !lsu_err_o && !axi_aw_valid_o &&
                !axi_w_valid_o && !axi_b_ready_o && !axi_ar_valid_o && !axi_r_ready_o) else
            stop_run("bridge outputs were not idle after reset");
        for (int n = 0; n < t_name.size(); n++) begin
            run_step(n);
        end
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/axi_slave_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_slave_mem (
    input  wire         clock,
    input  wire         reset_n,
    // write address
    input  wire         aw_valid_i,
    output bit          aw_ready_o,
    input  wire  [31:0] aw_addr_i,
    // write data
    input  wire         w_valid_i,
    output bit          w_ready_o,
    input  wire  [63:0] w_data_i,
    input  wire  [7:0]  w_strb_i,
    // write response
    output bit          b_valid_o,
    input  wire         b_ready_i,
    output bit   [1:0]  b_resp_o,
    // read address
    input  wire         ar_valid_i,
    output bit          ar_ready_o,
    input  wire  [31:0] ar_addr_i,
    // read data
    output bit          r_valid_o,
    input  wire         r_ready_i,
    output bit   [63:0] r_data_o,
    output bit   [1:0]  r_resp_o
);

    // 256 doublewords cover 2 KiB and everything above is the error region
    logic [63:0] mem [256];
    bit   [31:0] aw_addr_q;
    // stall cycles left before the next ready
    int unsigned aw_stall;
    int unsigned w_stall;
    int unsigned ar_stall;

    assign aw_ready_o = (aw_stall == 0);
    assign w_ready_o  = (w_stall == 0);
    assign ar_ready_o = (ar_stall == 0);

    // seeded once before the clocked loop that draws the stalls
    initial begin
        void'($urandom(32'h4104_068b));
        forever begin
            @(posedge clock);
            if (!reset_n) begin
                for (int i = 0; i < 256; i++) begin
                    mem[i] <= '0;
                end
                aw_addr_q <= '0;
                aw_stall  <= 0;
                w_stall   <= 0;
                ar_stall  <= 0;
                b_valid_o <= 1'b0;
                b_resp_o  <= axi_bridge_pkg::RESP_OKAY;
                r_valid_o <= 1'b0;
                r_data_o  <= '0;
                r_resp_o  <= axi_bridge_pkg::RESP_OKAY;
            end else begin
                // new random aw stall after each handshake
                if (aw_valid_i && aw_ready_o) begin
                    aw_addr_q <= aw_addr_i;
                    aw_stall  <= $urandom_range(3);
                end else if (aw_valid_i && aw_stall != 0) begin
                    aw_stall <= aw_stall - 1;
                end
                if (b_valid_o && b_ready_i) begin
                    b_valid_o <= 1'b0;
                end
                // w always follows aw here
                if (w_valid_i && w_ready_o) begin
                    w_stall   <= $urandom_range(3);
                    b_valid_o <= 1'b1;
                    if (aw_addr_q >= 32'h0000_0800) begin
                        b_resp_o <= axi_bridge_pkg::RESP_SLVERR;
                    end else begin
                        b_resp_o <= axi_bridge_pkg::RESP_OKAY;
                        // only strobed lanes land in memory
                        for (int i = 0; i < 8; i++) begin
                            if (w_strb_i[i]) begin
                                mem[aw_addr_q[10:3]][i*8 +: 8] <= w_data_i[i*8 +: 8];
                            end
                        end
                    end
                end else if (w_valid_i && w_stall != 0) begin
                    w_stall <= w_stall - 1;
                end
                if (r_valid_o && r_ready_i) begin
                    r_valid_o <= 1'b0;
                end
                // read data returned on the next cycle
                if (ar_valid_i && ar_ready_o) begin
                    ar_stall  <= $urandom_range(3);
                    r_valid_o <= 1'b1;
                    if (ar_addr_i >= 32'h0000_0800) begin
                        r_resp_o <= axi_bridge_pkg::RESP_SLVERR;
                        r_data_o <= '0;
                    end else begin
                        r_resp_o <= axi_bridge_pkg::RESP_OKAY;
                        r_data_o <= mem[ar_addr_i[10:3]];
                    end
                end else if (ar_valid_i && ar_stall != 0) begin
                    ar_stall <= ar_stall - 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/axi_bridge_top.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_bridge_top (
    input  wire                                   clock,
    input  wire                                   reset_n,
    // fetch port
    input  wire                                   if_valid_i,
    input  wire [axi_bridge_pkg::AXI_ADDR_W-1:0]  if_addr_i,
    output logic                                  if_ready_o,
    output logic [31:0]                           if_rdata_o,
    // load/store port
    input  wire                                   lsu_valid_i,
    input  wire                                   lsu_write_i,
    input  wire axi_bridge_pkg::size_e            lsu_size_i,
    input  wire [axi_bridge_pkg::AXI_ADDR_W-1:0]  lsu_addr_i,
    input  wire [axi_bridge_pkg::AXI_DATA_W-1:0]  lsu_wdata_i,
    output logic                                  lsu_ready_o,
    output logic [axi_bridge_pkg::AXI_DATA_W-1:0] lsu_rdata_o,
    output logic                                  lsu_err_o,
    // write address
    input  wire                                   axi_aw_ready_i,
    output logic                                  axi_aw_valid_o,
    output logic [axi_bridge_pkg::AXI_ADDR_W-1:0] axi_aw_addr_o,
    // write data
    input  wire                                   axi_w_ready_i,
    output logic                                  axi_w_valid_o,
    output logic [axi_bridge_pkg::AXI_DATA_W-1:0] axi_w_data_o,
    output logic [axi_bridge_pkg::AXI_STRB_W-1:0] axi_w_strb_o,
    output logic                                  axi_w_last_o,
    // write response
    output logic                                  axi_b_ready_o,
    input  wire                                   axi_b_valid_i,
    input  wire [1:0]                             axi_b_resp_i,
    // read address
    input  wire                                   axi_ar_ready_i,
    output logic                                  axi_ar_valid_o,
    output logic [axi_bridge_pkg::AXI_ADDR_W-1:0] axi_ar_addr_o,
    // read data
    output logic                                  axi_r_ready_o,
    input  wire                                   axi_r_valid_i,
    input  wire [1:0]                             axi_r_resp_i,
    input  wire [axi_bridge_pkg::AXI_DATA_W-1:0]  axi_r_data_i
);

    // granted request and its completion
    axi_rw_if rw_bus ();

    axi_port_arbiter u_arbiter (
        .clock       (clock),
        .reset_n     (reset_n),
        .if_valid_i  (if_valid_i),
        .if_addr_i   (if_addr_i),
        .if_ready_o  (if_ready_o),
        .if_rdata_o  (if_rdata_o),
        .lsu_valid_i (lsu_valid_i),
        .lsu_write_i (lsu_write_i),
        .lsu_size_i  (lsu_size_i),
        .lsu_addr_i  (lsu_addr_i),
        .lsu_wdata_i (lsu_wdata_i),
        .lsu_ready_o (lsu_ready_o),
        .lsu_rdata_o (lsu_rdata_o),
        .lsu_err_o   (lsu_err_o),
        .bus         (rw_bus)
    );

    // done_o already reaches the arbiter as the interface ready
    axi_master_ctrl u_ctrl (
        .clock      (clock),
        .reset_n    (reset_n),
        .bus        (rw_bus),
        .aw_ready_i (axi_aw_ready_i),
        .w_ready_i  (axi_w_ready_i),
        .b_valid_i  (axi_b_valid_i),
        .ar_ready_i (axi_ar_ready_i),
        .r_valid_i  (axi_r_valid_i),
        .aw_valid_o (axi_aw_valid_o),
        .w_valid_o  (axi_w_valid_o),
        .w_last_o   (axi_w_last_o),
        .b_ready_o  (axi_b_ready_o),
        .ar_valid_o (axi_ar_valid_o),
        .r_ready_o  (axi_r_ready_o),
        .b_resp_i   (axi_b_resp_i),
        .done_o     ()
    );

    axi_wdata_lane u_wdata (
        .bus       (rw_bus),
        .aw_addr_o (axi_aw_addr_o),
        .ar_addr_o (axi_ar_addr_o),
        .w_data_o  (axi_w_data_o),
        .w_strb_o  (axi_w_strb_o)
    );

    // r_ready comes back from the read FSM
    axi_rdata_align u_rdata (
        .clock     (clock),
        .reset_n   (reset_n),
        .bus       (rw_bus),
        .r_valid_i (axi_r_valid_i),
        .r_ready_i (axi_r_ready_o),
        .r_data_i  (axi_r_data_i),
        .r_resp_i  (axi_r_resp_i)
    );

endmodule

`default_nettype wire

/* design/axi_rdata_align.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_rdata_align (
    input  wire                                  clock,
    input  wire                                  reset_n,
    axi_rw_if.lane                               bus,
    input  wire                                  r_valid_i,
    input  wire                                  r_ready_i,
    input  wire [axi_bridge_pkg::AXI_DATA_W-1:0] r_data_i,
    input  wire [1:0]                            r_resp_i
);

    logic [axi_bridge_pkg::AXI_DATA_W-1:0] beat_q;
    logic [1:0]                            resp_q;
    logic [axi_bridge_pkg::AXI_DATA_W-1:0] shifted;
    logic [axi_bridge_pkg::AXI_DATA_W-1:0] size_mask;

    // beat register loads on the r handshake
    always_ff @(posedge clock) begin
        if (r_valid_i && r_ready_i) begin
            beat_q <= r_data_i;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            resp_q <= axi_bridge_pkg::RESP_OKAY;
        end else if (r_valid_i && r_ready_i) begin
            resp_q <= r_resp_i;
        end
    end

    // addressed bytes down to lane 0
    assign shifted = beat_q >> {bus.req.addr[axi_bridge_pkg::OFFSET_W-1:0], 3'b000};

    // zero-extend since the core handles sign
    always_comb begin
        case (bus.req.size)
            axi_bridge_pkg::SIZE_B: size_mask = 64'h0000_0000_0000_00ff;
            axi_bridge_pkg::SIZE_H: size_mask = 64'h0000_0000_0000_ffff;
            axi_bridge_pkg::SIZE_W: size_mask = 64'h0000_0000_ffff_ffff;
            default:                size_mask = 64'hffff_ffff_ffff_ffff;
        endcase
    end

    assign bus.rdata  = shifted & size_mask;
    assign bus.rd_err = (resp_q != axi_bridge_pkg::RESP_OKAY);

endmodule

`default_nettype wire

/* design/axi_wdata_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_wdata_lane (
    axi_rw_if.lane                                bus,
    output logic [axi_bridge_pkg::AXI_ADDR_W-1:0] aw_addr_o,
    output logic [axi_bridge_pkg::AXI_ADDR_W-1:0] ar_addr_o,
    output logic [axi_bridge_pkg::AXI_DATA_W-1:0] w_data_o,
    output logic [axi_bridge_pkg::AXI_STRB_W-1:0] w_strb_o
);

    logic [axi_bridge_pkg::OFFSET_W-1:0]   offset;
    logic [axi_bridge_pkg::AXI_ADDR_W-1:0] word_addr;
    logic [axi_bridge_pkg::AXI_STRB_W-1:0] strb_base;

    assign offset = bus.req.addr[axi_bridge_pkg::OFFSET_W-1:0];

    // bus address drops the byte offset
    assign word_addr = {bus.req.addr[axi_bridge_pkg::AXI_ADDR_W-1:axi_bridge_pkg::OFFSET_W],
                        {axi_bridge_pkg::OFFSET_W{1'b0}}};
    assign aw_addr_o = word_addr;
    assign ar_addr_o = word_addr;

    // move right-aligned data up to its byte lane
    assign w_data_o = bus.req.wdata << {offset, 3'b000};

    // run of ones, one per byte of the access
    always_comb begin
        case (bus.req.size)
            axi_bridge_pkg::SIZE_B: strb_base = 8'h01;
            axi_bridge_pkg::SIZE_H: strb_base = 8'h03;
            axi_bridge_pkg::SIZE_W: strb_base = 8'h0f;
            default:                strb_base = 8'hff;
        endcase
    end

    // lanes outside the strobe carry don't-care data
    assign w_strb_o = strb_base << offset;

endmodule

`default_nettype wire

/* design/axi_master_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_master_ctrl (
    input  wire        clock,
    input  wire        reset_n,
    axi_rw_if.responder bus,
    input  wire        aw_ready_i,
    input  wire        w_ready_i,
    input  wire        b_valid_i,
    input  wire        ar_ready_i,
    input  wire        r_valid_i,
    output logic       aw_valid_o,
    output logic       w_valid_o,
    output logic       w_last_o,
    output logic       b_ready_o,
    output logic       ar_valid_o,
    output logic       r_ready_o,
    input  wire [1:0]  b_resp_i,
    output logic       done_o
);

    typedef enum logic [1:0] {W_IDLE, W_ADDR, W_DATA, W_RESP} w_state_e;
    typedef enum logic [1:0] {R_IDLE, R_ADDR, R_DATA} r_state_e;

    w_state_e w_state;
    r_state_e r_state;
    logic     start;
    logic     aw_hs;
    logic     w_hs;
    logic     b_hs;
    logic     ar_hs;
    logic     r_hs;
    logic     wr_err_q;
    logic [axi_bridge_pkg::OFFSET_W:0] span;
    logic [axi_bridge_pkg::OFFSET_W:0] end_byte;

    // channel handshakes
    assign aw_hs = aw_valid_o & aw_ready_i;
    assign w_hs  = w_valid_o & w_ready_i;
    assign b_hs  = b_ready_o & b_valid_i;
    assign ar_hs = ar_valid_o & ar_ready_i;
    assign r_hs  = r_ready_o & r_valid_i;

    // valid is still high in the ready cycle so that cycle is skipped
    assign start = bus.valid & !done_o & (w_state == W_IDLE) & (r_state == R_IDLE);

    // write channel runs aw then w then b
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            w_state <= W_IDLE;
        end else begin
            case (w_state)
                W_IDLE: if (start && bus.req.write) w_state <= W_ADDR;
                W_ADDR: if (aw_hs) w_state <= W_DATA;
                W_DATA: if (w_hs) w_state <= W_RESP;
                W_RESP: if (b_hs) w_state <= W_IDLE;
                default: w_state <= W_IDLE;
            endcase
        end
    end

    // read channel runs ar then r
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            r_state <= R_IDLE;
        end else begin
            case (r_state)
                R_IDLE: if (start && !bus.req.write) r_state <= R_ADDR;
                R_ADDR: if (ar_hs) r_state <= R_DATA;
                R_DATA: if (r_hs) r_state <= R_IDLE;
                default: r_state <= R_IDLE;
            endcase
        end
    end

    assign aw_valid_o = (w_state == W_ADDR);
    // every w beat is the last of a single-beat transfer
    assign w_valid_o  = (w_state == W_DATA);
    assign w_last_o   = (w_state == W_DATA);
    assign b_ready_o  = (w_state == W_RESP);
    assign ar_valid_o = (r_state == R_ADDR);
    assign r_ready_o  = (r_state == R_DATA);

    // completion one cycle after b or r
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            done_o   <= 1'b0;
            wr_err_q <= 1'b0;
        end else begin
            done_o <= b_hs | r_hs;
            if (b_hs) begin
                wr_err_q <= (b_resp_i != axi_bridge_pkg::RESP_OKAY);
            end
        end
    end

    assign bus.ready = done_o;
    // req is still stable in the ready cycle
    assign bus.err   = bus.req.write ? wr_err_q : bus.rd_err;

    // last byte offset of the access
    always_comb begin
        case (bus.req.size)
            axi_bridge_pkg::SIZE_B: span = 4'd0;
            axi_bridge_pkg::SIZE_H: span = 4'd1;
            axi_bridge_pkg::SIZE_W: span = 4'd3;
            default:                span = 4'd7;
        endcase
    end
    assign end_byte = {1'b0, bus.req.addr[axi_bridge_pkg::OFFSET_W-1:0]} + span;

    // valid and the request behind it hold through a stall
    a_aw_hold: assert property (@(posedge clock) disable iff (!reset_n)
        aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(bus.req));
    a_ar_hold: assert property (@(posedge clock) disable iff (!reset_n)
        ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(bus.req));
    // no access may spill into the next bus word
    a_no_cross: assert property (@(posedge clock) disable iff (!reset_n)
        start |-> !end_byte[axi_bridge_pkg::OFFSET_W]);

endmodule

`default_nettype wire

/* design/axi_port_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_port_arbiter (
    input  wire                                   clock,
    input  wire                                   reset_n,
    // instruction fetch, read only
    input  wire                                   if_valid_i,
    input  wire [axi_bridge_pkg::AXI_ADDR_W-1:0]  if_addr_i,
    output logic                                  if_ready_o,
    output logic [31:0]                           if_rdata_o,
    // load/store
    input  wire                                   lsu_valid_i,
    input  wire                                   lsu_write_i,
    input  wire axi_bridge_pkg::size_e            lsu_size_i,
    input  wire [axi_bridge_pkg::AXI_ADDR_W-1:0]  lsu_addr_i,
    input  wire [axi_bridge_pkg::AXI_DATA_W-1:0]  lsu_wdata_i,
    output logic                                  lsu_ready_o,
    output logic [axi_bridge_pkg::AXI_DATA_W-1:0] lsu_rdata_o,
    output logic                                  lsu_err_o,
    axi_rw_if.requester                           bus
);

    // grant owners held until the ready pulse
    logic gnt_lsu_q;
    logic gnt_if_q;
    logic sel_lsu;
    logic sel_if;
    axi_bridge_pkg::rw_req_t fetch_req;
    axi_bridge_pkg::rw_req_t lsu_req;

    // locked grant first and otherwise load/store beats fetch
    assign sel_lsu = gnt_lsu_q | (!gnt_if_q & lsu_valid_i);
    assign sel_if  = gnt_if_q | (!gnt_lsu_q & !lsu_valid_i & if_valid_i);

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            gnt_lsu_q <= 1'b0;
            gnt_if_q  <= 1'b0;
        end else if (bus.ready) begin
            // release on completion
            gnt_lsu_q <= 1'b0;
            gnt_if_q  <= 1'b0;
        end else if (!gnt_lsu_q && !gnt_if_q) begin
            gnt_lsu_q <= sel_lsu;
            gnt_if_q  <= sel_if;
        end
    end

    // a fetch is always a word read
    assign fetch_req = '{write: 1'b0, size: axi_bridge_pkg::SIZE_W,
                         addr: if_addr_i, wdata: '0};
    assign lsu_req   = '{write: lsu_write_i, size: lsu_size_i,
                         addr: lsu_addr_i, wdata: lsu_wdata_i};

    assign bus.valid = (sel_lsu & lsu_valid_i) | (sel_if & if_valid_i);
    assign bus.req   = sel_if ? fetch_req : lsu_req;

    // completion back to the owner
    assign lsu_ready_o = bus.ready & gnt_lsu_q;
    assign lsu_rdata_o = bus.rdata;
    assign lsu_err_o   = bus.err & gnt_lsu_q;
    // fetch has no error output so its err is dropped
    assign if_ready_o  = bus.ready & gnt_if_q;
    assign if_rdata_o  = bus.rdata[31:0];

    // at most one owner and exactly one when a completion arrives
    a_single_grant: assert property (@(posedge clock) disable iff (!reset_n)
        bus.ready ? $onehot({gnt_lsu_q, gnt_if_q}) : $onehot0({gnt_lsu_q, gnt_if_q}));

endmodule

`default_nettype wire

/* design/axi_rw_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface axi_rw_if;

    // request side, held until ready
    logic                                    valid;
    axi_bridge_pkg::rw_req_t                 req;
    // completion, single-cycle pulse
    logic                                    ready;
    logic [axi_bridge_pkg::AXI_DATA_W-1:0]   rdata;
    logic                                    err;
    // read response flag from the read datapath
    logic                                    rd_err;

    // arbiter side
    modport requester (output valid, output req, input ready, input rdata, input err);

    // channel FSMs
    modport responder (input valid, input req, input rd_err, output ready, output err);

    // datapath blocks; only the read side drives rdata and rd_err
    modport lane (input req, output rdata, output rd_err);

endinterface

`default_nettype wire

/* design/axi_bridge_pkg.sv */
`default_nettype none

package axi_bridge_pkg;

    // bus geometry
    localparam int AXI_DATA_W = 64;
    localparam int AXI_ADDR_W = 32;
    // one strobe bit per byte lane
    localparam int AXI_STRB_W = AXI_DATA_W / 8;
    // byte offset inside one bus word
    localparam int OFFSET_W   = 3;

    // access size, bytes = 1 << size
    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2,
        SIZE_D = 2'd3
    } size_e;

    // b/r response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // one granted request
    // wdata is right-aligned, lanes are placed later
    typedef struct packed {
        logic                  write;
        size_e                 size;
        logic [AXI_ADDR_W-1:0] addr;
        logic [AXI_DATA_W-1:0] wdata;
    } rw_req_t;

endpackage

`default_nettype wire
